// ==== hdl/smpc_pkg.sv ====
package smpc_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [4:0]  oreg_addr_t;
	typedef logic [19:0] wait_cnt_t;

	typedef enum logic [2:0] {
		IDLE,
		WAIT,
		COMMAND,
		EXEC,
		END
	} cmd_state_t;

	localparam int IREG_NUM = 7;
	localparam int SMEM_NUM = 4;

	localparam oreg_addr_t OREG_LAST = 5'd31; // Command echo slot

	// Command codes
	localparam byte_t CMD_MSHON   = 8'h00;
	localparam byte_t CMD_SSHON   = 8'h02;
	localparam byte_t CMD_SSHOFF  = 8'h03;
	localparam byte_t CMD_SNDON   = 8'h06;
	localparam byte_t CMD_SNDOFF  = 8'h07;
	localparam byte_t CMD_CDON    = 8'h08;
	localparam byte_t CMD_CDOFF   = 8'h09;
	localparam byte_t CMD_INTBACK = 8'h10;
	localparam byte_t CMD_SETSMEM = 8'h17;
	localparam byte_t CMD_NMIREQ  = 8'h18;
	localparam byte_t CMD_RESENAB = 8'h19;
	localparam byte_t CMD_RESDISA = 8'h1A;

	// Wait counts in CE cycles
	localparam wait_cnt_t WAIT_ACCEPT  = 20'd90;
	localparam wait_cnt_t WAIT_LINE    = 20'd120;
	localparam wait_cnt_t WAIT_CD      = 20'd159;
	localparam wait_cnt_t WAIT_MEM     = 20'd159;
	localparam wait_cnt_t WAIT_NMI     = 20'd127;
	localparam wait_cnt_t WAIT_INTBACK = 20'd800;

	// Odd byte addresses on the host bus
	localparam logic [6:0] ADDR_IREG0  = 7'h01;
	localparam logic [6:0] ADDR_COMREG = 7'h1F;
	localparam logic [6:0] ADDR_OREG0  = 7'h21;
	localparam logic [6:0] ADDR_SR     = 7'h61;
	localparam logic [6:0] ADDR_SF     = 7'h63;

	localparam byte_t INTBACK_KEY     = 8'hF0;
	localparam byte_t SR_INTBACK_DONE = 8'h4F;

endpackage

// ==== hdl/smpc_host_if.sv ====
`timescale 1ns/10ps

interface smpc_host_if import smpc_pkg::*; ();

	byte_t comreg;
	logic  cmd_pend;                // High until the sequencer takes it
	byte_t ireg [IREG_NUM];
	logic  cmd_take;
	logic  sf_clear;
	byte_t sr;

	modport regs (
		output comreg,
		output cmd_pend,
		output ireg,
		input  cmd_take,
		input  sf_clear,
		input  sr
	);

	modport seq (
		input  comreg,
		input  cmd_pend,
		input  ireg,
		output cmd_take,
		output sf_clear,
		output sr
	);

endinterface

// ==== hdl/smpc_oreg_ram.sv ====
`timescale 1ns/10ps

module smpc_oreg_ram import smpc_pkg::*; (
	input  logic       CLK,
	input  oreg_addr_t wa,
	input  byte_t      wd,
	input  logic       we,
	input  oreg_addr_t ra,
	output byte_t      rd
);

	byte_t mem [0:OREG_LAST];

	always_ff @(posedge CLK) begin
		if (we) begin
			mem[wa] <= wd;
		end
	end

	assign rd = mem[ra]; // Asynchronous read for the host mux

endmodule

// ==== hdl/smpc_host_regs.sv ====
`timescale 1ns/10ps

module smpc_host_regs import smpc_pkg::*; (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       mres_n,
	input  logic [5:0] a,
	input  byte_t      di,
	input  logic       cs_n,
	input  logic       rw_n,
	input  byte_t      oreg_rd,
	output byte_t      dout,
	output oreg_addr_t oreg_ra,
	smpc_host_if.regs  host
);

	logic       rw_n_old;
	logic       cs_n_old;
	logic       wr_stb;
	logic       rd_stb;
	logic       sf;
	logic [6:0] addr;
	logic [6:0] ireg_off;
	logic [6:0] oreg_off;
	logic       oreg_hit;
	byte_t      rd_data;

	assign addr     = {a, 1'b1};
	assign ireg_off = addr - ADDR_IREG0;
	assign oreg_off = addr - ADDR_OREG0;
	assign oreg_ra  = oreg_off[5:1];
	assign oreg_hit = (addr >= ADDR_OREG0) && (oreg_off[6:1] <= {1'b0, OREG_LAST});

	// Strobes fire on the first sampled edge of the bus cycle
	assign wr_stb = mres_n && !cs_n && !rw_n && rw_n_old;
	assign rd_stb = mres_n && !cs_n && cs_n_old && rw_n;

	always_comb begin
		if (oreg_hit) begin
			rd_data = oreg_rd;
		end else if (addr == ADDR_SR) begin
			rd_data = host.sr;
		end else if (addr == ADDR_SF) begin
			rd_data = {7'b0000000, sf};
		end else begin
			rd_data = '0;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rw_n_old <= 1'b1;
			cs_n_old <= 1'b1;
		end else if (mres_n) begin
			rw_n_old <= rw_n;
			cs_n_old <= cs_n;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			host.comreg   <= '0;
			host.cmd_pend <= 1'b0;
			host.ireg     <= '{default: '0};
			sf            <= 1'b0;
		end else begin
			if (host.cmd_take) host.cmd_pend <= 1'b0;
			if (host.sf_clear) sf <= 1'b0;

			// A new write wins over a clear in the same cycle
			if (wr_stb) begin
				if (addr == ADDR_COMREG) begin
					host.comreg   <= di;
					host.cmd_pend <= 1'b1;
				end else if (addr == ADDR_SF) begin
					if (di[0]) sf <= 1'b1;
				end else if (ireg_off < 7'(2 * IREG_NUM)) begin
					host.ireg[ireg_off[3:1]] <= di;
				end
			end
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			dout <= '0;
		end else if (rd_stb) begin
			dout <= rd_data; // Held until the next read
		end
	end

endmodule

// ==== hdl/smpc_cmd_seq.sv ====
`timescale 1ns/10ps

module smpc_cmd_seq import smpc_pkg::*; (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       ce,
	input  logic       mres_n,
	input  logic       time_set,
	input  logic [3:0] ac,
	output logic       mshres_n,
	output logic       mshnmi_n,
	output logic       sshres_n,
	output logic       sshnmi_n,
	output logic       sndres_n,
	output logic       cdres_n,
	output logic       mirq_n,
	output oreg_addr_t oreg_wa,
	output byte_t      oreg_wd,
	output logic       oreg_we,
	smpc_host_if.seq   host
);

	cmd_state_t state;
	cmd_state_t next_st;
	wait_cnt_t  wait_cnt;
	wait_cnt_t  cmd_wait;
	oreg_addr_t oreg_cnt;
	logic       resd;
	logic       ste;
	logic       intback_ok;
	byte_t      smem [SMEM_NUM];
	byte_t      status_byte;

	assign intback_ok = (host.ireg[2] == INTBACK_KEY) && host.ireg[0][0];

	always_comb begin
		case (host.comreg)
			CMD_MSHON, CMD_SSHON, CMD_SSHOFF,
			CMD_SNDON, CMD_SNDOFF:              cmd_wait = WAIT_LINE;
			CMD_CDON, CMD_CDOFF:                cmd_wait = WAIT_CD;
			CMD_INTBACK:                        cmd_wait = WAIT_INTBACK;
			CMD_SETSMEM:                        cmd_wait = WAIT_MEM;
			CMD_NMIREQ, CMD_RESENAB, CMD_RESDISA: cmd_wait = WAIT_NMI;
			default:                            cmd_wait = '0;
		endcase
	end

	// INTBACK status block with the RTC slots at zero
	always_comb begin
		case (oreg_cnt)
			5'd0:  status_byte = {ste, resd, 6'b000000};
			5'd9:  status_byte = {4'b0000, ac};
			5'd10: status_byte = {4'b0011, ~mshnmi_n, 1'b1, 1'b0, ~sndres_n};
			5'd11: status_byte = {1'b0, ~cdres_n, 6'b000000};
			5'd12, 5'd13, 5'd14, 5'd15: status_byte = smem[oreg_cnt[1:0]];
			OREG_LAST: status_byte = host.comreg;
			default: status_byte = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (ce && mres_n && state == EXEC && host.comreg == CMD_SETSMEM) begin
			for (int i = 0; i < SMEM_NUM; i++) smem[i] <= host.ireg[i];
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state         <= IDLE;
			next_st       <= IDLE;
			wait_cnt      <= '0;
			oreg_cnt      <= '0;
			mshres_n      <= 1'b0;
			mshnmi_n      <= 1'b0;
			sshres_n      <= 1'b0;
			sshnmi_n      <= 1'b0;
			sndres_n      <= 1'b0;
			cdres_n       <= 1'b0;
			mirq_n        <= 1'b1;
			resd          <= 1'b1;
			ste           <= 1'b0;
			host.sr       <= '0;
			host.cmd_take <= 1'b0;
			host.sf_clear <= 1'b0;
			oreg_wa       <= '0;
			oreg_wd       <= '0;
			oreg_we       <= 1'b0;
		end else if (!mres_n) begin // Soft master reset
			mshres_n      <= 1'b1;
			mshnmi_n      <= 1'b1;
			sshres_n      <= 1'b0;
			sshnmi_n      <= 1'b1;
			sndres_n      <= 1'b0;
			cdres_n       <= 1'b1;
			mirq_n        <= 1'b1;
			resd          <= 1'b1;
			ste           <= time_set;
			host.sr       <= '0;
			host.cmd_take <= 1'b0;
			host.sf_clear <= 1'b0;
			oreg_we       <= 1'b0;
			state         <= IDLE;
		end else begin
			oreg_we       <= 1'b0;
			host.cmd_take <= 1'b0;
			host.sf_clear <= 1'b0;

			if (ce) begin
				if (wait_cnt != '0) wait_cnt <= wait_cnt - 20'd1;

				case (state)
					IDLE: begin
						mirq_n <= 1'b1;
						if (host.cmd_pend) begin
							host.cmd_take <= 1'b1;
							oreg_cnt      <= '0;
							wait_cnt      <= WAIT_ACCEPT;
							next_st       <= COMMAND;
							state         <= WAIT;
						end
					end

					WAIT: begin
						if (wait_cnt == '0) state <= next_st;
					end

					COMMAND: begin
						if (host.comreg == CMD_INTBACK && !intback_ok) begin
							state <= END; // Bad key skips the OREG update
						end else if (cmd_wait != '0) begin
							wait_cnt <= cmd_wait;
							next_st  <= EXEC;
							state    <= WAIT;
						end else begin
							state <= EXEC;
						end
					end

					EXEC: begin
						oreg_wa <= OREG_LAST;
						oreg_wd <= host.comreg;
						oreg_we <= 1'b1;
						state   <= END;
						case (host.comreg)
							CMD_MSHON: begin
								mshres_n <= 1'b1;
								mshnmi_n <= 1'b1;
							end
							CMD_SSHON: begin
								sshres_n <= 1'b1;
								sshnmi_n <= 1'b1;
							end
							CMD_SSHOFF: begin
								sshres_n <= 1'b0;
								sshnmi_n <= 1'b1;
							end
							CMD_SNDON:   sndres_n <= 1'b1;
							CMD_SNDOFF:  sndres_n <= 1'b0;
							CMD_CDON:    cdres_n <= 1'b1;
							CMD_CDOFF:   cdres_n <= 1'b0;
							CMD_NMIREQ:  mshnmi_n <= 1'b0;
							CMD_RESENAB: resd <= 1'b0;
							CMD_RESDISA: resd <= 1'b1;
							CMD_INTBACK: begin
								oreg_wa  <= oreg_cnt;
								oreg_wd  <= status_byte;
								oreg_cnt <= oreg_cnt + 5'd1;
								if (oreg_cnt == OREG_LAST) begin
									host.sr <= SR_INTBACK_DONE;
									mirq_n  <= 1'b0;
								end else begin
									state <= EXEC; // One slot per cycle
								end
							end
							default: ;
						endcase
					end

					END: begin
						if (host.comreg == CMD_NMIREQ) mshnmi_n <= 1'b1;
						host.sf_clear <= 1'b1;
						state         <= IDLE;
					end

					default: state <= IDLE;
				endcase
			end
		end
	end

endmodule

// ==== hdl/smpc_top.sv ====
`timescale 1ns/10ps

module smpc_top import smpc_pkg::*; (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       ce,
	input  logic       mres_n,
	input  logic       time_set,
	input  logic [3:0] ac,
	input  logic [5:0] a,
	input  byte_t      di,
	input  logic       cs_n,
	input  logic       rw_n,
	output byte_t      dout,
	output logic       mshres_n,
	output logic       mshnmi_n,
	output logic       sshres_n,
	output logic       sshnmi_n,
	output logic       sndres_n,
	output logic       cdres_n,
	output logic       mirq_n
);

	oreg_addr_t oreg_wa;
	oreg_addr_t oreg_ra;
	byte_t      oreg_wd;
	byte_t      oreg_rd;
	logic       oreg_we;

	smpc_host_if host_bus ();

	smpc_host_regs u_regs (
		.CLK     (CLK),
		.RST_N   (RST_N),
		.mres_n  (mres_n),
		.a       (a),
		.di      (di),
		.cs_n    (cs_n),
		.rw_n    (rw_n),
		.oreg_rd (oreg_rd),
		.dout    (dout),
		.oreg_ra (oreg_ra),
		.host    (host_bus.regs)
	);

	smpc_cmd_seq u_seq (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.ce       (ce),
		.mres_n   (mres_n),
		.time_set (time_set),
		.ac       (ac),
		.mshres_n (mshres_n),
		.mshnmi_n (mshnmi_n),
		.sshres_n (sshres_n),
		.sshnmi_n (sshnmi_n),
		.sndres_n (sndres_n),
		.cdres_n  (cdres_n),
		.mirq_n   (mirq_n),
		.oreg_wa  (oreg_wa),
		.oreg_wd  (oreg_wd),
		.oreg_we  (oreg_we),
		.host     (host_bus.seq)
	);

	smpc_oreg_ram u_oreg (
		.CLK (CLK),
		.wa  (oreg_wa),
		.wd  (oreg_wd),
		.we  (oreg_we),
		.ra  (oreg_ra),
		.rd  (oreg_rd)
	);

endmodule

// ==== testbench/smpc_chk.sv ====
`timescale 1ns/10ps

module smpc_chk import smpc_pkg::*; (
	input logic  CLK,
	input logic  RST_N,
	input logic  mres_n,
	input logic  cs_n,
	input logic  rw_n,
	input byte_t dout,
	input logic  mshres_n,
	input logic  mshnmi_n,
	input logic  sshres_n,
	input logic  sshnmi_n,
	input logic  sndres_n,
	input logic  cdres_n,
	input logic  mirq_n
);

	int   fail_cnt = 0;
	logic cs_n_q;
	logic read_seen;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cs_n_q <= 1'b1;
		end else if (mres_n) begin
			cs_n_q <= cs_n;
		end
	end

	assign read_seen = mres_n && !cs_n && cs_n_q && rw_n; // Read strobe edge

	outputs_known: assert property (@(posedge CLK) disable iff (!RST_N)
		!$isunknown({dout, mshres_n, mshnmi_n, sshres_n, sshnmi_n, sndres_n, cdres_n, mirq_n}))
		else begin $error("output unknown after reset"); fail_cnt++; end

	mirq_in_mres: assert property (@(posedge CLK) disable iff (!RST_N)
		(!mres_n && $past(!mres_n)) |-> mirq_n)
		else begin $error("mirq_n low during soft reset"); fail_cnt++; end

	sshnmi_no_fall: assert property (@(posedge CLK) disable iff (!RST_N) !$fell(sshnmi_n))
		else begin $error("sshnmi_n fell outside reset"); fail_cnt++; end

	dout_on_read: assert property (@(posedge CLK) disable iff (!RST_N)
		$changed(dout) |-> $past(read_seen))
		else begin $error("dout changed without a read strobe"); fail_cnt++; end

endmodule

bind smpc_top smpc_chk u_chk (.*);

// ==== testbench/smpc_tb.sv ====
`timescale 1ns/10ps

module smpc_tb import smpc_pkg::*; ();

	localparam int SF_TIMEOUT = 5000;

	logic       CLK;
	logic       RST_N;
	logic       ce;
	logic       mres_n;
	logic       time_set;
	logic [3:0] ac;
	logic [5:0] a;
	byte_t      di;
	logic       cs_n;
	logic       rw_n;
	byte_t      dout;
	logic       mshres_n;
	logic       mshnmi_n;
	logic       sshres_n;
	logic       sshnmi_n;
	logic       sndres_n;
	logic       cdres_n;
	logic       mirq_n;

	int          errors = 0;
	int          checks = 0;
	logic [31:0] rng = 32'd79;
	logic        mirq_low = 1'b0;
	logic        nmi_low = 1'b0;
	logic [6:0]  exp_lines; // mshres, mshnmi, sshres, sshnmi, sndres, cdres, mirq
	logic        exp_resd;
	logic        exp_ste;

	smpc_top uut (.*);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	always @(negedge CLK) begin
		if (!mirq_n) mirq_low = 1'b1;
		if (!mshnmi_n) nmi_low = 1'b1;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [6:0] oreg_addr(input int n);
		return ADDR_OREG0 + 7'(2 * n);
	endfunction

	task automatic check_val(input string name, input byte_t exp, input byte_t act);
		checks++;
		assert (act === exp)
		else begin
			$display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_flag(input logic cond, input string what);
		checks++;
		assert (cond)
		else begin
			$display("Check failed at %0t: %s", $time, what);
			errors++;
		end
	endtask

	task automatic finish_sim;
		int total;
		total = errors + uut.u_chk.fail_cnt;
		$display("checks %0d errors %0d assertion failures %0d", checks, errors,
			uut.u_chk.fail_cnt);
		if (total == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	endtask

	task automatic write_reg(input logic [6:0] addr, input byte_t data);
		@(posedge CLK);
		#2;
		a = addr[6:1];
		di = data;
		cs_n = 1'b0;
		rw_n = 1'b0;
		repeat (4) @(posedge CLK);
		#2;
		cs_n = 1'b1;
		rw_n = 1'b1;
	endtask

	task automatic read_reg(input logic [6:0] addr, output byte_t data);
		@(posedge CLK);
		#2;
		a = addr[6:1];
		cs_n = 1'b0;
		rw_n = 1'b1;
		repeat (4) @(posedge CLK);
		#2;
		cs_n = 1'b1;
		data = dout; // Held since the strobe
	endtask

	task automatic expect_reg(input logic [6:0] addr, input string name, input byte_t exp);
		byte_t data;
		read_reg(addr, data);
		check_val(name, exp, data);
	endtask

	task automatic check_lines;
		check_val("mshres_n", 8'(exp_lines[6]), 8'(mshres_n));
		check_val("mshnmi_n", 8'(exp_lines[5]), 8'(mshnmi_n));
		check_val("sshres_n", 8'(exp_lines[4]), 8'(sshres_n));
		check_val("sshnmi_n", 8'(exp_lines[3]), 8'(sshnmi_n));
		check_val("sndres_n", 8'(exp_lines[2]), 8'(sndres_n));
		check_val("cdres_n", 8'(exp_lines[1]), 8'(cdres_n));
		check_val("mirq_n", 8'(exp_lines[0]), 8'(mirq_n));
	endtask

	task automatic pulse_mres;
		mres_n = 1'b0;
		repeat (3) @(posedge CLK);
		#2;
		check_lines();
		mres_n = 1'b1;
	endtask

	task automatic wait_irq;
		int cycles;
		cycles = 0;
		while (mirq_n && cycles < SF_TIMEOUT) begin
			@(posedge CLK);
			#2;
			cycles++;
		end
		if (mirq_n) begin
			$display("Timeout: mirq_n did not go low within %0d cycles", SF_TIMEOUT);
			errors++;
			finish_sim();
		end
	endtask

	task automatic wait_done;
		byte_t sf;
		int    cycles;
		cycles = 0;
		read_reg(ADDR_SF, sf);
		while (sf[0] && cycles < SF_TIMEOUT) begin
			read_reg(ADDR_SF, sf);
			cycles += 5;
		end
		if (sf[0]) begin
			$display("Timeout: SF did not clear within %0d cycles", SF_TIMEOUT);
			errors++;
			finish_sim();
		end
	endtask

	task automatic run_cmd(input byte_t cmd);
		write_reg(ADDR_SF, 8'h01);
		write_reg(ADDR_COMREG, cmd);
		wait_done();
		case (cmd) // Expected line effects
			CMD_MSHON:   exp_lines[6:5] = 2'b11;
			CMD_SSHON:   exp_lines[4:3] = 2'b11;
			CMD_SSHOFF:  exp_lines[4:3] = 2'b01;
			CMD_SNDON:   exp_lines[2] = 1'b1;
			CMD_SNDOFF:  exp_lines[2] = 1'b0;
			CMD_CDON:    exp_lines[1] = 1'b1;
			CMD_CDOFF:   exp_lines[1] = 1'b0;
			CMD_RESENAB: exp_resd = 1'b0;
			CMD_RESDISA: exp_resd = 1'b1;
			default: ;
		endcase
	endtask

	initial begin
		byte_t mem_bytes [SMEM_NUM];
		byte_t bad_key;
		byte_t line_cmds [7];
		line_cmds = '{CMD_SSHON, CMD_SSHOFF, CMD_SNDON, CMD_SNDOFF, CMD_CDOFF, CMD_CDON,
			CMD_MSHON};
		RST_N = 1'b0;
		ce = 1'b1;
		mres_n = 1'b1;
		time_set = 1'b1;
		ac = 4'hA;
		a = '0;
		di = '0;
		cs_n = 1'b1;
		rw_n = 1'b1;
		repeat (8) @(posedge CLK);
		#2;
		RST_N = 1'b1;

		// Soft master reset pulse
		@(posedge CLK);
		#2;
		exp_lines = 7'b1101011;
		exp_resd = 1'b1;
		exp_ste = time_set;
		pulse_mres();
		expect_reg(ADDR_SR, "sr", 8'h00);

		foreach (line_cmds[i]) begin
			run_cmd(line_cmds[i]);
			check_lines();
			expect_reg(oreg_addr(OREG_LAST), "oreg31", line_cmds[i]);
		end

		nmi_low = 1'b0;
		run_cmd(CMD_NMIREQ);
		check_flag(nmi_low, "mshnmi_n never went low during NMIREQ");
		check_lines();
		expect_reg(oreg_addr(OREG_LAST), "oreg31", CMD_NMIREQ);

		// Battery memory, then a valid status INTBACK
		for (int i = 0; i < SMEM_NUM; i++) begin
			rng = xorshift32(rng);
			mem_bytes[i] = rng[7:0];
			write_reg(ADDR_IREG0 + 7'(2 * i), mem_bytes[i]);
		end
		run_cmd(CMD_SETSMEM);
		rng = xorshift32(rng);
		write_reg(ADDR_IREG0, rng[7:0] | 8'h01);
		write_reg(ADDR_IREG0 + 7'd4, INTBACK_KEY);
		mirq_low = 1'b0;
		run_cmd(CMD_INTBACK);
		check_flag(mirq_low, "mirq_n never went low during INTBACK");
		for (int i = 0; i < SMEM_NUM; i++) begin
			expect_reg(oreg_addr(12 + i), $sformatf("oreg%0d", 12 + i), mem_bytes[i]);
		end
		expect_reg(oreg_addr(9), "oreg9", {4'h0, ac});
		expect_reg(oreg_addr(0), "oreg0", {exp_ste, exp_resd, 6'b000000});
		expect_reg(ADDR_SR, "sr", SR_INTBACK_DONE);

		run_cmd(CMD_RESENAB);
		run_cmd(CMD_INTBACK);
		expect_reg(oreg_addr(0), "oreg0", {exp_ste, exp_resd, 6'b000000});
		run_cmd(CMD_RESDISA);
		run_cmd(CMD_INTBACK);
		expect_reg(oreg_addr(0), "oreg0", {exp_ste, exp_resd, 6'b000000});

		// Status flag and a rejected INTBACK
		write_reg(ADDR_SF, 8'h01);
		expect_reg(ADDR_SF, "sf", 8'h01);
		rng = xorshift32(rng);
		bad_key = rng[7:0];
		if (bad_key == INTBACK_KEY) bad_key = ~bad_key;
		write_reg(ADDR_IREG0 + 7'd4, bad_key);
		mirq_low = 1'b0;
		run_cmd(CMD_INTBACK);
		expect_reg(ADDR_SF, "sf", 8'h00);
		check_flag(!mirq_low, "mirq_n went low on an INTBACK with a bad key");
		check_lines();

		// Soft reset while the INTBACK interrupt is pending
		write_reg(ADDR_IREG0 + 7'd4, INTBACK_KEY);
		write_reg(ADDR_SF, 8'h01);
		write_reg(ADDR_COMREG, CMD_INTBACK);
		wait_irq();
		pulse_mres();
		expect_reg(ADDR_SR, "sr", 8'h00);

		finish_sim();
	end

endmodule

// ==== filelist.f ====
hdl/smpc_pkg.sv
hdl/smpc_host_if.sv
hdl/smpc_oreg_ram.sv
hdl/smpc_host_regs.sv
hdl/smpc_cmd_seq.sv
hdl/smpc_top.sv
testbench/smpc_chk.sv
testbench/smpc_tb.sv

// ==== Bender.yml ====
package:
  name: smpc

sources:
  - files:
      - hdl/smpc_pkg.sv
      - hdl/smpc_host_if.sv
      - hdl/smpc_oreg_ram.sv
      - hdl/smpc_host_regs.sv
      - hdl/smpc_cmd_seq.sv
      - hdl/smpc_top.sv
  - target: test
    files:
      - testbench/smpc_chk.sv
      - testbench/smpc_tb.sv
